//--- design/dcache_defs.svh
//////////////////////////////////////////////////
// Global widths and sizes of the data cache
// Included by the package and by every RTL block
// that sizes a vector or a storage array
//////////////////////////////////////////////////

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Core data and physical address widths
`define DCACHE_XLEN     32
`define DCACHE_PLEN     32

// Direct-mapped, one word per line
`define DCACHE_SETS     16
`define DCACHE_IDX_BITS 4
// Tag is what is left above index and byte offset
`define DCACHE_TAG_BITS (`DCACHE_PLEN - `DCACHE_IDX_BITS - 2)

// Memory credits granted after reset
`define DCACHE_CREDITS  4

// Width of the hit and miss counters
`define DCACHE_CNT_W    16

`endif

//--- design/dcache_pkg.sv
//////////////////////////////////////////////////
// Types shared by all data cache blocks
// Referenced by scoped name from each module
//////////////////////////////////////////////////

`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

  // Address, data and lane types
  typedef logic [`DCACHE_PLEN-1:0]     adr_t;
  typedef logic [`DCACHE_XLEN-1:0]     data_t;
  typedef logic [`DCACHE_XLEN/8-1:0]   be_t;

  // Line addressing
  typedef logic [`DCACHE_TAG_BITS-1:0] tag_t;
  typedef logic [`DCACHE_IDX_BITS-1:0] idx_t;

  // Access size, encoded as byte 0, halfword 1, word 2
  typedef logic [1:0]                  size_t;
  localparam size_t SIZE_BYTE  = 2'd0;
  localparam size_t SIZE_HWORD = 2'd1;
  localparam size_t SIZE_WORD  = 2'd2;

  // Controller FSM
  typedef enum logic [1:0] {IDLE, MISS_REQ, MISS_WAIT, WR_REQ} ctrl_state_t;

  // Counters and memory credits
  typedef logic [`DCACHE_CNT_W-1:0]    cnt_t;
  typedef logic [2:0]                  credit_t;

endpackage

`default_nettype wire

//--- design/dcache_tag.sv
//////////////////////////////////////////////////
// Tag stage of the data cache
// Registers an accepted core request and hands it
// to the controller one cycle later
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              stall_i,
  input  logic              flush_i,
  input  logic              req_i,
  input  logic              we_i,
  input  dcache_pkg::adr_t  adr_i,
  input  dcache_pkg::size_t size_i,
  input  dcache_pkg::data_t d_i,

  output logic              req_o,
  output logic              wreq_o,
  output dcache_pkg::adr_t  adr_o,
  output dcache_pkg::size_t size_o,
  output dcache_pkg::be_t   be_o,
  output dcache_pkg::data_t q_o,
  output dcache_pkg::tag_t  core_tag_o
);

  //////////////////////////////////////////////////
  // Byte enables from size and low address bits

  function automatic dcache_pkg::be_t size2be(input dcache_pkg::size_t size,
                                              input logic [1:0]        lsbs);
    dcache_pkg::be_t be;
    unique case (size)
      dcache_pkg::SIZE_BYTE:  be = 4'h1 << lsbs;
      dcache_pkg::SIZE_HWORD: be = 4'h3 << lsbs;
      default:                be = 4'hf;
    endcase
    return be;
  endfunction

  //////////////////////////////////////////////////
  // Request valid bits

  // A flush drops the request being accepted
  // A stalled request is held, so a pending miss still completes
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      req_o  <= 1'b0;
      wreq_o <= 1'b0;
    end
    else if (!stall_i)
    begin
      req_o  <= req_i & ~flush_i;
      wreq_o <= req_i & we_i & ~flush_i;
    end
  end

  //////////////////////////////////////////////////
  // Request payload

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      adr_o  <= adr_i;
      size_o <= size_i;
      be_o   <= size2be(size_i, adr_i[1:0]);
      // Write data moved onto the addressed byte lanes
      q_o    <= d_i << {adr_i[1:0], 3'b000};
    end
  end

  // Tag bits of the registered address
  assign core_tag_o = adr_o[`DCACHE_PLEN-1 -: `DCACHE_TAG_BITS];

endmodule

`default_nettype wire

//--- design/dcache_array.sv
//////////////////////////////////////////////////
// Line storage of the data cache
// Valid, tag and data flops with a combinational
// read port and a byte-masked write port
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_array (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              inval_all_i,

  // Lookup
  input  dcache_pkg::idx_t  rd_idx_i,
  output logic              valid_o,
  output dcache_pkg::tag_t  tag_o,
  output dcache_pkg::data_t data_o,

  // Fill and update
  input  logic              we_i,
  input  dcache_pkg::idx_t  wr_idx_i,
  input  dcache_pkg::tag_t  wr_tag_i,
  input  dcache_pkg::be_t   be_i,
  input  dcache_pkg::data_t wr_data_i
);

  logic [`DCACHE_SETS-1:0] valid_q;
  dcache_pkg::tag_t        tag_q  [`DCACHE_SETS];
  dcache_pkg::data_t       data_q [`DCACHE_SETS];

  // Valid bits, invalidate-all wins over a write in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= '0;
    else if (inval_all_i)
      valid_q <= '0;
    else if (we_i)
      valid_q[wr_idx_i] <= 1'b1;
  end

  // Tag and data, only enabled bytes are merged
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      tag_q[wr_idx_i] <= wr_tag_i;
      for (int b = 0; b < `DCACHE_XLEN/8; b++)
      begin
        if (be_i[b])
          data_q[wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
      end
    end
  end

  // Combinational lookup
  assign valid_o = valid_q[rd_idx_i];
  assign tag_o   = tag_q[rd_idx_i];
  assign data_o  = data_q[rd_idx_i];

endmodule

`default_nettype wire

//--- design/dcache_ctrl.sv
//////////////////////////////////////////////////
// Data cache controller
// Hit detection, read miss and write handling,
// memory request issue and credit bookkeeping
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cache_en_i,

  // From the tag stage
  input  logic              req_i,
  input  logic              wreq_i,
  input  dcache_pkg::adr_t  adr_i,
  input  dcache_pkg::be_t   be_i,
  input  dcache_pkg::data_t d_i,
  input  dcache_pkg::tag_t  core_tag_i,

  // From the array
  input  logic              line_valid_i,
  input  dcache_pkg::tag_t  line_tag_i,
  input  dcache_pkg::data_t line_data_i,

  // Core response
  output logic              stall_o,
  output logic              ack_o,
  output dcache_pkg::data_t rdata_o,

  // Array write port
  output logic              arr_we_o,
  output dcache_pkg::idx_t  arr_idx_o,
  output dcache_pkg::tag_t  arr_tag_o,
  output dcache_pkg::be_t   arr_be_o,
  output dcache_pkg::data_t arr_data_o,

  // Memory side
  output logic              mem_req_o,
  output logic              mem_we_o,
  output dcache_pkg::adr_t  mem_adr_o,
  output dcache_pkg::be_t   mem_be_o,
  output dcache_pkg::data_t mem_wdata_o,
  input  logic              mem_credit_i,
  input  logic              mem_rvalid_i,
  input  dcache_pkg::data_t mem_rdata_i,

  // Statistics
  output logic              hit_o,
  output logic              miss_o
);

  dcache_pkg::ctrl_state_t state_q, state_d;
  dcache_pkg::credit_t     credit_q;
  logic                    tag_match;
  logic                    hit;
  logic                    credit_ok;
  logic                    filling;

  //////////////////////////////////////////////////
  // Lookup

  // Tag match alone keeps lines coherent on writes while disabled
  assign tag_match = line_valid_i & (line_tag_i == core_tag_i);
  assign hit       = cache_en_i & tag_match;
  assign credit_ok = (credit_q != '0);
  assign filling   = (state_q == dcache_pkg::MISS_WAIT);

  //////////////////////////////////////////////////
  // FSM

  always_comb
  begin
    state_d   = state_q;
    stall_o   = 1'b0;
    ack_o     = 1'b0;
    mem_req_o = 1'b0;
    mem_we_o  = 1'b0;
    arr_we_o  = 1'b0;
    hit_o     = 1'b0;
    miss_o    = 1'b0;

    unique case (state_q)
      dcache_pkg::IDLE:
      begin
        if (req_i && wreq_i)
        begin
          // Write-through, no allocate on miss
          if (credit_ok)
          begin
            mem_req_o = 1'b1;
            mem_we_o  = 1'b1;
            ack_o     = 1'b1;
            arr_we_o  = tag_match;
          end
          else
          begin
            stall_o = 1'b1;
            state_d = dcache_pkg::WR_REQ;
          end
        end
        else if (req_i && hit)
        begin
          ack_o = 1'b1;
          hit_o = 1'b1;
        end
        else if (req_i)
        begin
          // Read miss or uncached read
          miss_o  = 1'b1;
          stall_o = 1'b1;
          if (credit_ok)
          begin
            mem_req_o = 1'b1;
            state_d   = dcache_pkg::MISS_WAIT;
          end
          else
            state_d = dcache_pkg::MISS_REQ;
        end
      end

      dcache_pkg::MISS_REQ:
      begin
        stall_o = 1'b1;
        if (credit_ok)
        begin
          mem_req_o = 1'b1;
          state_d   = dcache_pkg::MISS_WAIT;
        end
      end

      dcache_pkg::MISS_WAIT:
      begin
        if (mem_rvalid_i)
        begin
          // Refill only while enabled
          ack_o    = 1'b1;
          arr_we_o = cache_en_i;
          state_d  = dcache_pkg::IDLE;
        end
        else
          stall_o = 1'b1;
      end

      dcache_pkg::WR_REQ:
      begin
        if (credit_ok)
        begin
          mem_req_o = 1'b1;
          mem_we_o  = 1'b1;
          ack_o     = 1'b1;
          arr_we_o  = tag_match;
          state_d   = dcache_pkg::IDLE;
        end
        else
          stall_o = 1'b1;
      end

      default: state_d = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= dcache_pkg::IDLE;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////
  // Credits

  // One spent per request, one returned per consumed request
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      credit_q <= dcache_pkg::credit_t'(`DCACHE_CREDITS);
    else
      credit_q <= credit_q - dcache_pkg::credit_t'(mem_req_o)
                           + dcache_pkg::credit_t'(mem_credit_i);
  end

  //////////////////////////////////////////////////
  // Datapath

  // Word-aligned memory address, reads fetch the whole word
  assign mem_adr_o   = {adr_i[`DCACHE_PLEN-1:2], 2'b00};
  assign mem_be_o    = wreq_i ? be_i : '1;
  assign mem_wdata_o = d_i;

  // Fill writes a full word, a write hit merges its own bytes
  assign arr_idx_o   = adr_i[2 +: `DCACHE_IDX_BITS];
  assign arr_tag_o   = core_tag_i;
  assign arr_be_o    = filling ? '1 : be_i;
  assign arr_data_o  = filling ? mem_rdata_i : d_i;

  assign rdata_o     = filling ? mem_rdata_i : line_data_i;

endmodule

`default_nettype wire

//--- design/dcache_csr.sv
//////////////////////////////////////////////////
// Configuration registers of the data cache
// Enable, invalidate-all command and statistics
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_csr (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              cfg_we_i,
  input  logic [1:0]        cfg_adr_i,
  input  dcache_pkg::data_t cfg_wdata_i,
  output dcache_pkg::data_t cfg_rdata_o,

  input  logic              hit_i,
  input  logic              miss_i,

  output logic              cache_en_o,
  output logic              inval_all_o
);

  dcache_pkg::cnt_t hit_cnt_q;
  dcache_pkg::cnt_t miss_cnt_q;
  logic             ctrl_we;

  assign ctrl_we = cfg_we_i & (cfg_adr_i == 2'd0);

  // Enable bit and self-clearing invalidate pulse
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cache_en_o  <= 1'b0;
      inval_all_o <= 1'b0;
    end
    else
    begin
      inval_all_o <= ctrl_we & cfg_wdata_i[1];
      if (ctrl_we)
        cache_en_o <= cfg_wdata_i[0];
    end
  end

  // Wrapping statistics counters
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      hit_cnt_q  <= '0;
      miss_cnt_q <= '0;
    end
    else
    begin
      if (hit_i)
        hit_cnt_q <= hit_cnt_q + 1'b1;
      if (miss_i)
        miss_cnt_q <= miss_cnt_q + 1'b1;
    end
  end

  // Read mux, invalidate bit reads as zero
  always_comb
  begin
    unique case (cfg_adr_i)
      2'd0:    cfg_rdata_o = dcache_pkg::data_t'(cache_en_o);
      2'd1:    cfg_rdata_o = dcache_pkg::data_t'(hit_cnt_q);
      2'd2:    cfg_rdata_o = dcache_pkg::data_t'(miss_cnt_q);
      default: cfg_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
//////////////////////////////////////////////////
// Write-through direct-mapped data cache
// Sits between a load/store unit and a credit-based
// memory port, with a small configuration port
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Core
  input  logic              req_i,
  input  logic              we_i,
  input  dcache_pkg::adr_t  adr_i,
  input  dcache_pkg::size_t size_i,
  input  dcache_pkg::data_t wdata_i,
  input  logic              flush_i,
  output logic              stall_o,
  output logic              ack_o,
  output dcache_pkg::data_t rdata_o,

  // Memory
  output logic              mem_req_o,
  output logic              mem_we_o,
  output dcache_pkg::adr_t  mem_adr_o,
  output dcache_pkg::be_t   mem_be_o,
  output dcache_pkg::data_t mem_wdata_o,
  input  logic              mem_credit_i,
  input  logic              mem_rvalid_i,
  input  dcache_pkg::data_t mem_rdata_i,

  // Configuration
  input  logic              cfg_we_i,
  input  logic [1:0]        cfg_adr_i,
  input  dcache_pkg::data_t cfg_wdata_i,
  output dcache_pkg::data_t cfg_rdata_o
);

  // Tag stage outputs
  logic              tag_req;
  logic              tag_wreq;
  dcache_pkg::adr_t  tag_adr;
  dcache_pkg::be_t   tag_be;
  dcache_pkg::data_t tag_wdata;
  dcache_pkg::tag_t  core_tag;

  // Array lookup and write
  logic              line_valid;
  dcache_pkg::tag_t  line_tag;
  dcache_pkg::data_t line_data;
  logic              arr_we;
  dcache_pkg::idx_t  arr_idx;
  dcache_pkg::tag_t  arr_tag;
  dcache_pkg::be_t   arr_be;
  dcache_pkg::data_t arr_data;

  // Configuration and statistics
  logic              cache_en;
  logic              inval_all;
  logic              hit_pulse;
  logic              miss_pulse;

  //////////////////////////////////////////////////
  // Tag stage, access width travels on as byte enables

  dcache_tag i_tag (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stall_i    (stall_o),
    .flush_i    (flush_i),
    .req_i      (req_i),
    .we_i       (we_i),
    .adr_i      (adr_i),
    .size_i     (size_i),
    .d_i        (wdata_i),
    .req_o      (tag_req),
    .wreq_o     (tag_wreq),
    .adr_o      (tag_adr),
    .size_o     (),
    .be_o       (tag_be),
    .q_o        (tag_wdata),
    .core_tag_o (core_tag)
  );

  dcache_array i_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .inval_all_i (inval_all),
    .rd_idx_i    (tag_adr[2 +: `DCACHE_IDX_BITS]),
    .valid_o     (line_valid),
    .tag_o       (line_tag),
    .data_o      (line_data),
    .we_i        (arr_we),
    .wr_idx_i    (arr_idx),
    .wr_tag_i    (arr_tag),
    .be_i        (arr_be),
    .wr_data_i   (arr_data)
  );

  dcache_ctrl i_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cache_en_i   (cache_en),
    .req_i        (tag_req),
    .wreq_i       (tag_wreq),
    .adr_i        (tag_adr),
    .be_i         (tag_be),
    .d_i          (tag_wdata),
    .core_tag_i   (core_tag),
    .line_valid_i (line_valid),
    .line_tag_i   (line_tag),
    .line_data_i  (line_data),
    .stall_o      (stall_o),
    .ack_o        (ack_o),
    .rdata_o      (rdata_o),
    .arr_we_o     (arr_we),
    .arr_idx_o    (arr_idx),
    .arr_tag_o    (arr_tag),
    .arr_be_o     (arr_be),
    .arr_data_o   (arr_data),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_adr_o    (mem_adr_o),
    .mem_be_o     (mem_be_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_credit_i (mem_credit_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .hit_o        (hit_pulse),
    .miss_o       (miss_pulse)
  );

  dcache_csr i_csr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_adr_i   (cfg_adr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .hit_i       (hit_pulse),
    .miss_i      (miss_pulse),
    .cache_en_o  (cache_en),
    .inval_all_o (inval_all)
  );

endmodule

`default_nettype wire

//--- sim/dcache_checker.sv
//////////////////////////////////////////////////
// Checker for the data cache testbench
// Tracks accepted requests and a reference memory,
// compares memory writes and read data on each ack
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  dcache_pkg::adr_t  adr_i,
  input  dcache_pkg::size_t size_i,
  input  dcache_pkg::data_t wdata_i,
  input  logic              flush_i,
  input  logic              stall_o,
  input  logic              ack_o,
  input  dcache_pkg::data_t rdata_o,
  input  logic              mem_req_o,
  input  logic              mem_we_o,
  input  dcache_pkg::adr_t  mem_adr_o,
  input  dcache_pkg::be_t   mem_be_o,
  input  dcache_pkg::data_t mem_wdata_o
);

  logic [31:0] ref_mem [64];
  logic        p_we    [$];
  logic [31:0] p_adr   [$];
  logic [1:0]  p_size  [$];
  logic [31:0] p_wdata [$];

  int errors    = 0;
  int checks    = 0;
  int acks      = 0;
  int mem_reqs  = 0;
  int mem_reads = 0;

  // Initial memory word, a mix of the whole word index
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return (idx * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  // Byte lanes touched by an access of a given size
  function automatic logic [3:0] lanes(input logic [1:0] size, input logic [1:0] lsbs);
    if (size == 2'd0)
      return 4'b0001 << lsbs;
    else if (size == 2'd1)
      return 4'b0011 << lsbs;
    return 4'b1111;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  initial
  begin
    for (int i = 0; i < 64; i++)
      ref_mem[i] = fill_word(i);
  end

  //////////////////////////////////////////////////
  // Sampling after the falling edge, all settled

  always
  begin
    logic        we;
    logic [31:0] adr;
    logic [1:0]  size;
    logic [31:0] wdata;
    logic [31:0] mask;
    @(negedge clk_i);
    #2;
    if (rst_ni)
    begin
      // Request counts, a read must fetch the word of the oldest pending request
      if (mem_req_o)
      begin
        mem_reqs++;
        if (!mem_we_o)
        begin
          mem_reads++;
          if (p_we.size() == 0 || p_we[0])
            note_error("memory read issued with no read pending");
          else
            check_value("mem_adr_o", mem_adr_o, {p_adr[0][31:2], 2'b00});
        end
      end
      if (ack_o)
      begin
        acks++;
        if (p_we.size() == 0)
          note_error("ack_o seen with no request outstanding");
        else
        begin
          we    = p_we.pop_front();
          adr   = p_adr.pop_front();
          size  = p_size.pop_front();
          wdata = p_wdata.pop_front();
          if (we)
          begin
            // A write is acked in the cycle it goes to memory
            mask = lane_mask(lanes(size, adr[1:0]));
            check_value("mem_req_o", 32'(mem_req_o & mem_we_o), 32'd1);
            check_value("mem_adr_o", mem_adr_o, {adr[31:2], 2'b00});
            check_value("mem_be_o", 32'(mem_be_o), 32'(lanes(size, adr[1:0])));
            check_value("mem_wdata_o", mem_wdata_o & mask,
                        (wdata << {adr[1:0], 3'b000}) & mask);
            // Reference memory follows the core's writes in order
            ref_mem[adr[7:2]] = (ref_mem[adr[7:2]] & ~mask)
                              | ((wdata << {adr[1:0], 3'b000}) & mask);
          end
          else
            check_value("rdata_o", rdata_o, ref_mem[adr[7:2]]);
        end
      end
      // Accepted at the next rising edge
      if (req_i && !stall_o && !flush_i)
      begin
        p_we.push_back(we_i);
        p_adr.push_back(adr_i);
        p_size.push_back(size_i);
        p_wdata.push_back(wdata_i);
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/dcache_asserts.sv
//////////////////////////////////////////////////
// Handshake and credit assertions for the cache
// Bound into every instance of the top level
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_asserts (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic stall_o,
  input  logic ack_o,
  input  logic mem_req_o,
  input  logic mem_credit_i
);

  // Requests issued and not yet returned as credits
  logic [3:0] outstanding_q;
  int         fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      outstanding_q <= '0;
    else
      outstanding_q <= outstanding_q + 4'(mem_req_o) - 4'(mem_credit_i);
  end

  a_credit_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q <= `DCACHE_CREDITS)
  else
  begin
    $error("more memory requests outstanding than credits");
    fail_count++;
  end

  // No request may go out once every credit is spent
  a_no_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (outstanding_q == `DCACHE_CREDITS) |-> !mem_req_o)
  else
  begin
    $error("memory request issued without a credit");
    fail_count++;
  end

  a_ack_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ack_o && stall_o))
  else
  begin
    $error("ack_o and stall_o high together");
    fail_count++;
  end

endmodule

bind dcache_top dcache_asserts i_asserts (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .stall_o      (stall_o),
  .ack_o        (ack_o),
  .mem_req_o    (mem_req_o),
  .mem_credit_i (mem_credit_i)
);

`default_nettype wire

//--- sim/dcache_tb.sv
//////////////////////////////////////////////////
// Testbench top for the data cache
// Random core and config traffic, credit-based
// memory model, checker and bound assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int TIMEOUT = 200;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              req_i, we_i, flush_i;
  dcache_pkg::adr_t  adr_i;
  dcache_pkg::size_t size_i;
  dcache_pkg::data_t wdata_i;
  logic              stall_o, ack_o;
  dcache_pkg::data_t rdata_o;
  logic              mem_req_o, mem_we_o;
  dcache_pkg::adr_t  mem_adr_o;
  dcache_pkg::be_t   mem_be_o;
  dcache_pkg::data_t mem_wdata_o, mem_rdata_i;
  logic              mem_credit_i, mem_rvalid_i;
  logic              cfg_we_i;
  logic [1:0]        cfg_adr_i;
  dcache_pkg::data_t cfg_wdata_i, cfg_rdata_o;

  integer seed = 77;
  int     test_no = 0;
  int     err_mark = 0;
  logic   hold_credits = 1'b0;

  // Memory model state
  logic [31:0] mem_words [64];
  logic        q_we   [$];
  logic [31:0] q_adr  [$];
  logic [3:0]  q_be   [$];
  logic [31:0] q_data [$];
  int          owed = 0;
  int          delay = 0;

  always #4 clk_i = ~clk_i;

  dcache_top i_dut (.*);

  dcache_checker i_chk (.*);

  //////////////////////////////////////////////////
  // Memory model, in order, random latency

  always @(negedge clk_i)
  begin
    logic [31:0] mask;
    mem_rvalid_i = 1'b0;
    mem_credit_i = 1'b0;
    if (!rst_ni)
    begin
      owed  = 0;
      delay = 0;
    end
    else
    begin
      if (q_adr.size() > 0)
      begin
        if (delay > 0)
          delay--;
        else
        begin
          mask = {{8{q_be[0][3]}}, {8{q_be[0][2]}}, {8{q_be[0][1]}}, {8{q_be[0][0]}}};
          if (q_we[0])
            mem_words[q_adr[0][7:2]] = (mem_words[q_adr[0][7:2]] & ~mask) | (q_data[0] & mask);
          else
          begin
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = mem_words[q_adr[0][7:2]];
          end
          void'(q_we.pop_front());
          void'(q_adr.pop_front());
          void'(q_be.pop_front());
          void'(q_data.pop_front());
          owed++;
          delay = $unsigned($random(seed)) % 4;
        end
      end
      if (!hold_credits && owed > 0 && $random(seed) % 2 == 0)
      begin
        mem_credit_i = 1'b1;
        owed--;
      end
      // Pushed last so a request is served one cycle later at the earliest
      if (mem_req_o)
      begin
        q_we.push_back(mem_we_o);
        q_adr.push_back(mem_adr_o);
        q_be.push_back(mem_be_o);
        q_data.push_back(mem_wdata_o);
      end
    end
  end

  //////////////////////////////////////////////////
  // Core and config drivers

  task automatic issue(input logic we, input logic [31:0] adr, input logic [1:0] size,
                       input logic [31:0] wdata, input logic flush);
    int n;
    n = 0;
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    adr_i   = adr;
    size_i  = size;
    wdata_i = wdata;
    flush_i = flush;
    #1;
    while (stall_o && n < TIMEOUT)
    begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (stall_o)
      i_chk.note_error("request never accepted, stall_o stuck high");
    @(negedge clk_i);
    req_i   = 1'b0;
    flush_i = 1'b0;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    #1;
    while (!ack_o && n < TIMEOUT)
    begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!ack_o)
      i_chk.note_error("no ack_o within the timeout");
  endtask

  task automatic access(input logic we, input logic [31:0] adr, input logic [1:0] size,
                        input logic [31:0] wdata);
    issue(we, adr, size, wdata, 1'b0);
    wait_ack();
  endtask

  task automatic cfg_write(input logic [1:0] adr, input logic [31:0] data);
    @(negedge clk_i);
    cfg_we_i    = 1'b1;
    cfg_adr_i   = adr;
    cfg_wdata_i = data;
    @(negedge clk_i);
    cfg_we_i    = 1'b0;
  endtask

  task automatic cfg_read(input logic [1:0] adr, output logic [31:0] data);
    @(negedge clk_i);
    cfg_adr_i = adr;
    #1;
    data = cfg_rdata_o;
  endtask

  // Memory idle with every credit back
  task automatic drain();
    int n;
    n = 0;
    while ((q_adr.size() > 0 || owed > 0) && n < TIMEOUT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (q_adr.size() > 0 || owed > 0)
      i_chk.note_error("memory did not drain within the timeout");
  endtask

  task automatic test_done(input string name);
    test_no++;
    $display("test %0d %s: done, %0d errors", test_no, name, i_chk.errors - err_mark);
    err_mark = i_chk.errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    logic [31:0] v0, v1, d;
    int          r0, a0, total;
    logic [31:0] a;
    logic [1:0]  sz;
    for (int i = 0; i < 64; i++)
      mem_words[i] = i_chk.fill_word(i);
    rst_ni = 1'b0;
    {req_i, we_i, flush_i, cfg_we_i} = '0;
    adr_i = '0;
    size_i = '0;
    wdata_i = '0;
    cfg_adr_i = '0;
    cfg_wdata_i = '0;
    mem_rdata_i = '0;
    mem_rvalid_i = 1'b0;
    mem_credit_i = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    cfg_write(2'd0, 32'd1);

    // Byte and halfword merges at every offset
    access(1'b1, 32'h40, 2'd2, $random(seed));
    access(1'b0, 32'h40, 2'd2, 0);
    for (int off = 0; off < 4; off++)
    begin
      access(1'b1, 32'h40 + off, 2'd0, $random(seed));
      access(1'b0, 32'h40, 2'd2, 0);
    end
    for (int off = 0; off < 4; off += 2)
    begin
      access(1'b1, 32'h40 + off, 2'd1, $random(seed));
      access(1'b0, 32'h40, 2'd2, 0);
    end
    test_done("write/read merges");

    // Repeated hit, then an aliasing miss
    access(1'b0, 32'h10, 2'd2, 0);
    cfg_read(2'd1, v0);
    r0 = i_chk.mem_reqs;
    access(1'b0, 32'h10, 2'd2, 0);
    cfg_read(2'd1, v1);
    i_chk.check_value("mem_req count", i_chk.mem_reqs, r0);
    i_chk.check_value("hit count", v1, v0 + 1);
    cfg_read(2'd2, v0);
    r0 = i_chk.mem_reads;
    access(1'b0, 32'h50, 2'd2, 0);
    cfg_read(2'd2, v1);
    i_chk.check_value("miss count", v1, v0 + 1);
    i_chk.check_value("mem read count", i_chk.mem_reads, r0 + 1);
    test_done("hit and alias miss");

    // Disabled cache reads straight from memory, even a cached word
    cfg_write(2'd0, 32'd0);
    cfg_read(2'd2, v0);
    r0 = i_chk.mem_reads;
    access(1'b0, 32'h50, 2'd2, 0);
    access(1'b0, 32'h10, 2'd2, 0);
    access(1'b0, 32'h10, 2'd2, 0);
    cfg_read(2'd2, v1);
    i_chk.check_value("miss count", v1, v0 + 3);
    i_chk.check_value("mem read count", i_chk.mem_reads, r0 + 3);
    cfg_write(2'd0, 32'd1);
    test_done("cache disabled");

    // Invalidate-all forces a refetch
    access(1'b0, 32'h24, 2'd2, 0);
    access(1'b0, 32'h24, 2'd2, 0);
    r0 = i_chk.mem_reads;
    cfg_write(2'd0, 32'd3);
    // Enable stays set, the invalidate bit reads as zero
    cfg_read(2'd0, v0);
    i_chk.check_value("cfg_rdata_o", v0, 32'd1);
    access(1'b0, 32'h24, 2'd2, 0);
    i_chk.check_value("mem read count", i_chk.mem_reads, r0 + 1);
    test_done("invalidate-all");

    // Credits held back, then random traffic
    drain();
    hold_credits = 1'b1;
    for (int i = 0; i < 4; i++)
      access(1'b1, 32'h80 + 4 * i, 2'd2, $random(seed));
    issue(1'b1, 32'h90, 2'd2, $random(seed), 1'b0);
    repeat (20)
    begin
      @(negedge clk_i);
      #1;
      i_chk.check_value("stall_o", 32'(stall_o), 32'd1);
      i_chk.check_value("ack_o", 32'(ack_o), 32'd0);
    end
    hold_credits = 1'b0;
    wait_ack();
    for (int i = 0; i < 200; i++)
    begin
      if ($random(seed) % 16 == 0)
        cfg_write(2'd0, {30'd0, 1'($random(seed)), 1'b1});
      if ($random(seed) % 8 == 0)
      begin
        // Memory keeps consuming while its credits are held back
        hold_credits = 1'b1;
        repeat (1 + $unsigned($random(seed)) % 8) @(negedge clk_i);
        hold_credits = 1'b0;
      end
      a  = 32'($unsigned($random(seed)) % 64) << 2;
      sz = 2'($unsigned($random(seed)) % 3);
      d  = $random(seed);
      if (sz == 2'd0)
        a = a + 32'($unsigned($random(seed)) % 4);
      else if (sz == 2'd1)
        a = a + 32'(2 * ($unsigned($random(seed)) % 2));
      access(1'($random(seed)), a, sz, d);
    end
    hold_credits = 1'b0;
    test_done("credit back-pressure and random traffic");

    // Flushed request leaves no trace
    drain();
    r0 = i_chk.mem_reqs;
    a0 = i_chk.acks;
    issue(1'b0, 32'h30, 2'd2, 0, 1'b1);
    repeat (5) @(negedge clk_i);
    i_chk.check_value("mem_req count", i_chk.mem_reqs, r0);
    i_chk.check_value("ack count", i_chk.acks, a0);
    test_done("flush");

    total = i_chk.errors + i_dut.i_asserts.fail_count;
    $display("tests %0d, checks %0d, errors %0d", test_no, i_chk.checks, total);
    if (total == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/dcache_pkg.sv
design/dcache_tag.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache_csr.sv
design/dcache_top.sv
sim/dcache_checker.sv
sim/dcache_asserts.sv
sim/dcache_tb.sv
